// File: build.f
design/monitor_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_decode.sv
design/cmd_execute.sv
design/resp_format.sv
design/system.sv
tests/system_sva.sv
tests/system_tb.sv

// File: run.sh
#!/bin/sh
# builds the system testbench with verilator and runs it once.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module system_tb \
   --Mdir obj_dir -o system_sim
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

sim_output=$(./obj_dir/system_sim)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_output" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
exit 1

// File: tests/system_tb.sv
`timescale 1ns/100ps
`default_nettype none

module system_tb;

   import monitor_pkg::*;

   localparam longint watchdog_ns = longint'(60) * 40 * clks_per_bit * 100;

   logic        clk;
   logic        rst;
   logic [7:0]  sw;
   logic        rxd;
   logic [7:0]  led;
   logic        txd;

   logic [31:0] rng;
   int          value_errors;
   int          other_errors;
   logic [7:0]  rx_q [$];
   logic [7:0]  mem_model [256];
   logic [7:0]  led_model;
   logic [7:0]  addrs [8];

   system DUT (
      .clk (clk),
      .rst (rst),
      .sw  (sw),
      .led (led),
      .rxd (rxd),
      .txd (txd)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic random_byte(output logic [7:0] value);
      rng = xorshift32(rng);
      value = rng[7:0];
   endtask

   function automatic result_t result_of(input res_kind_e kind, input logic [7:0] data);
      result_t r;
      r.kind = kind;
      r.data = data;
      return r;
   endfunction

   // a response byte read back as the result that produced it.
   function automatic result_t classify_byte(input logic [7:0] b);
      result_t r;
      r = result_of(res_data, b);
      if (b === ack_byte) begin
         r = result_of(res_ack, 8'h00);
      end else if (b === bad_byte) begin
         r = result_of(res_bad, 8'h00);
      end
      return r;
   endfunction

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         value_errors++;
         $display("error: %0t ns, %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         value_errors++;
         $display("error: %0t ns, led = %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic check_res(input string name, input result_t got, input result_t exp);
      if (got.kind !== exp.kind || (exp.kind == res_data && got.data !== exp.data)) begin
         value_errors++;
         $display("error: %0t ns, %s = %s %h, expected %s %h", $time, name,
                  got.kind.name(), got.data, exp.kind.name(), exp.data);
      end
   endtask

   task automatic wait_bits(input int bits);
      repeat (bits * clks_per_bit) @(posedge clk);
      #10;
   endtask

   task automatic send_byte(input logic [7:0] value, input bit bad_stop);
      logic [9:0] frame;
      int i;
      frame = {~bad_stop, value, 1'b0};
      for (i = 0; i < 9; i++) begin
         rxd = frame[0];
         frame = frame >> 1;
         repeat (clks_per_bit) @(posedge clk);
         #10;
      end
      rxd = frame[0];
      if (bad_stop) begin
         // the low stop bit spans its center and the line rises before the next start bit.
         repeat (clks_per_bit * 3 / 4) @(posedge clk);
         #10;
         rxd = 1'b1;
         repeat (clks_per_bit - clks_per_bit * 3 / 4) @(posedge clk);
      end else begin
         repeat (clks_per_bit) @(posedge clk);
      end
      #10;
   endtask

   task automatic send_frame(input logic [7:0] op, input logic [7:0] addr,
                             input logic [7:0] data);
      send_byte(op, 1'b0);
      send_byte(addr, 1'b0);
      send_byte(data, 1'b0);
   endtask

   task automatic recv_byte(output logic [7:0] b);
      int waited;
      waited = 0;
      while (rx_q.size() == 0 && waited < 40 * clks_per_bit) begin
         @(posedge clk);
         #10;
         waited++;
      end
      if (rx_q.size() == 0) begin
         other_errors++;
         $display("no response byte arrived on txd within 40 bit times, at %0t ns", $time);
         b = 8'hxx;
      end else begin
         b = rx_q.pop_front();
      end
   endtask

   task automatic expect_silence(input int bits);
      wait_bits(bits);
      if (rx_q.size() != 0) begin
         other_errors++;
         $display("%0d unexpected response bytes on txd before %0t ns", rx_q.size(), $time);
         rx_q.delete();
      end
   endtask

   task automatic run_command(input logic [7:0] op, input logic [7:0] addr,
                              input logic [7:0] data, output logic [7:0] resp);
      send_frame(op, addr, data);
      recv_byte(resp);
   endtask

   task automatic reset_state();
      bit idle_ok;
      idle_ok = 1'b1;
      repeat (5 * clks_per_bit) begin
         @(posedge clk);
         #10;
         if (txd !== 1'b1) begin
            idle_ok = 1'b0;
         end
      end
      if (!idle_ok) begin
         other_errors++;
         $display("txd left the idle level after reset");
      end
      check_led(led, 8'h00);
   endtask

   task automatic write_read_back();
      logic [7:0] a;
      logic [7:0] d;
      logic [7:0] resp;
      int i;
      for (i = 0; i < 8; i++) begin
         random_byte(a);
         random_byte(d);
         addrs[i] = a;
         mem_model[a] = d;
         run_command(op_write, a, d, resp);
         check_res("write response", classify_byte(resp), result_of(res_ack, 8'h00));
      end
      for (i = 0; i < 8; i++) begin
         run_command(op_read, addrs[i], 8'h00, resp);
         check_byte("read data", resp, mem_model[addrs[i]]);
      end
   endtask

   task automatic led_and_switch();
      logic [7:0] d;
      logic [7:0] s;
      logic [7:0] resp;
      random_byte(d);
      led_model = d;
      run_command(op_led, 8'h00, d, resp);
      check_res("led response", classify_byte(resp), result_of(res_ack, 8'h00));
      check_led(led, led_model);
      random_byte(s);
      sw = s;
      run_command(op_switch, 8'h00, 8'h00, resp);
      check_byte("switch data", resp, s);
   endtask

   task automatic unknown_opcode();
      logic [7:0] resp;
      run_command(8'h5A, addrs[0], ~mem_model[addrs[0]], resp);
      check_res("unknown opcode response", classify_byte(resp), result_of(res_bad, 8'h00));
      run_command(op_read, addrs[0], 8'h00, resp);
      check_byte("read after unknown opcode", resp, mem_model[addrs[0]]);
      check_led(led, led_model);
   endtask

   task automatic gap_timeout();
      logic [7:0] resp;
      send_byte(op_write, 1'b0);
      send_byte(addrs[1], 1'b0);
      expect_silence(gap_bits + 5);
      run_command(op_read, addrs[1], 8'h00, resp);
      check_byte("read after gap", resp, mem_model[addrs[1]]);
      expect_silence(15);
   endtask

   task automatic framing_error();
      logic [7:0] a;
      logic [7:0] d;
      logic [7:0] junk;
      logic [7:0] resp;
      random_byte(a);
      random_byte(d);
      random_byte(junk);
      send_byte(op_write, 1'b0);
      send_byte(a, 1'b0);
      send_byte(junk, 1'b1);
      send_byte(d, 1'b0);
      recv_byte(resp);
      check_res("write response", classify_byte(resp), result_of(res_ack, 8'h00));
      expect_silence(15);
      mem_model[a] = d;
      run_command(op_read, a, 8'h00, resp);
      check_byte("read after framing error", resp, mem_model[a]);
   endtask

   // collects every byte on txd, sampled at bit centers.
   initial begin : uart_monitor
      logic [7:0] b;
      wait (rst === 1'b0);
      forever begin
         @(posedge clk);
         #10;
         if (txd === 1'b0) begin
            repeat (clks_per_bit / 2) @(posedge clk);
            #10;
            if (txd !== 1'b0) begin
               other_errors++;
               $display("start bit on txd shorter than half a bit at %0t ns", $time);
            end
            repeat (8) begin
               repeat (clks_per_bit) @(posedge clk);
               #10;
               b = {txd, b[7:1]};
            end
            repeat (clks_per_bit) @(posedge clk);
            #10;
            if (txd !== 1'b1) begin
               other_errors++;
               $display("stop bit on txd was low at %0t ns", $time);
            end
            rx_q.push_back(b);
         end
      end
   end

   initial begin
      #(watchdog_ns);
      $display("watchdog expired before the tests finished");
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      sw = 8'h00;
      rxd = 1'b1;
      rng = 32'd59632;
      value_errors = 0;
      other_errors = 0;
      led_model = 8'h00;
      repeat (2) @(posedge clk);
      #10;
      rst = 1'b0;
      reset_state();
      write_read_back();
      led_and_switch();
      unknown_opcode();
      gap_timeout();
      framing_error();
      $display("tests done: %0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/system_sva.sv
`timescale 1ns/100ps
`default_nettype none

module system_sva #(
   parameter bit tx_checks = 1'b0
) (
   input wire logic clk,
   input wire logic rst,
   input wire logic strobe,
   input wire logic busy,
   input wire logic line
);

   // a strobe lasts exactly one cycle.
   strobe_single : assert property (@(posedge clk) disable iff (rst) strobe |=> !strobe)
      else $error("strobe high in two consecutive cycles");

   generate
      if (tx_checks) begin : g_tx
         // the transmitter must be idle when a new byte is handed over.
         start_when_idle : assert property (@(posedge clk) disable iff (rst) strobe |-> !busy)
            else $error("tx_start arrived during a transmission");

         line_idle_after_reset : assert property (@(posedge clk) $fell(rst) |-> line)
            else $error("serial line low in the cycle after reset");
      end
   endgenerate

endmodule

// only the strobe check applies to the decoder.
bind cmd_decode system_sva #(.tx_checks(1'b0)) decode_sva (
   .clk    (clk),
   .rst    (rst),
   .strobe (cmd_valid),
   .busy   (1'b0),
   .line   (1'b1)
);

bind uart_tx system_sva #(.tx_checks(1'b1)) tx_sva (
   .clk    (clk),
   .rst    (rst),
   .strobe (tx_start),
   .busy   (busy),
   .line   (txd)
);

`default_nettype wire

// File: design/system.sv
`timescale 1ns/100ps
`default_nettype none

module system (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic [7:0] sw,
   output logic [7:0]      led,
   input  wire logic       rxd,
   output logic            txd
);

   import monitor_pkg::*;

   logic       rx_valid;
   logic [7:0] rx_byte;
   logic       cmd_valid;
   cmd_t       cmd;
   logic       res_valid;
   result_t    res;
   logic       tx_start;
   logic [7:0] tx_byte;

   uart_rx uart_rx (
      .clk      (clk),
      .rst      (rst),
      .rxd      (rxd),
      .rx_valid (rx_valid),
      .rx_byte  (rx_byte)
   );

   cmd_decode cmd_decode (
      .clk       (clk),
      .rst       (rst),
      .rx_valid  (rx_valid),
      .rx_byte   (rx_byte),
      .cmd_valid (cmd_valid),
      .cmd       (cmd)
   );

   cmd_execute cmd_execute (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .sw        (sw),
      .led       (led),
      .res_valid (res_valid),
      .res       (res)
   );

   resp_format resp_format (
      .clk       (clk),
      .rst       (rst),
      .res_valid (res_valid),
      .res       (res),
      .tx_start  (tx_start),
      .tx_byte   (tx_byte)
   );

   // one response per frame keeps the transmitter idle at each start.
   uart_tx uart_tx (
      .clk      (clk),
      .rst      (rst),
      .tx_start (tx_start),
      .tx_byte  (tx_byte),
      .txd      (txd)
   );

endmodule

`default_nettype wire

// File: design/resp_format.sv
`timescale 1ns/100ps
`default_nettype none

module resp_format (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       res_valid,
   input  monitor_pkg::result_t res,
   output logic            tx_start,
   output logic [7:0]      tx_byte
);

   import monitor_pkg::*;

   logic [7:0] byte_c;

   always_comb begin
      case (res.kind)
         res_ack:  byte_c = ack_byte;
         res_data: byte_c = res.data;
         default:  byte_c = bad_byte;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_start <= 1'b0;
      end else begin
         tx_start <= res_valid;
      end
   end

   always_ff @(posedge clk) begin
      tx_byte <= byte_c;
   end

endmodule

`default_nettype wire

// File: design/cmd_execute.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_execute (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       cmd_valid,
   input  monitor_pkg::cmd_t cmd,
   input  wire logic [7:0] sw,
   output logic [7:0]      led,
   output logic            res_valid,
   output monitor_pkg::result_t res
);

   import monitor_pkg::*;

   logic [7:0] ram [2**ram_addr_bits];

   res_kind_e  kind_c;
   logic       use_ram_c;

   // first pipeline stage.
   logic       valid_1;
   res_kind_e  kind_1;
   logic       use_ram_1;
   logic [7:0] sw_1;
   logic [7:0] rd_1;

   always_comb begin
      kind_c    = res_bad;
      use_ram_c = 1'b0;
      case (cmd.op)
         op_write: kind_c = res_ack;
         op_read: begin
            kind_c    = res_data;
            use_ram_c = 1'b1;
         end
         op_led: kind_c = res_ack;
         op_switch: kind_c = res_data;
         default: kind_c = res_bad;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_1   <= 1'b0;
         res_valid <= 1'b0;
         led       <= 8'h00;
      end else begin
         valid_1   <= cmd_valid;
         res_valid <= valid_1;
         if (cmd_valid && cmd.op == op_led) begin
            led <= cmd.data;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_valid && cmd.op == op_write) begin
         ram[cmd.addr[ram_addr_bits-1:0]] <= cmd.data;
      end
      rd_1      <= ram[cmd.addr[ram_addr_bits-1:0]];
      kind_1    <= kind_c;
      use_ram_1 <= use_ram_c;
      sw_1      <= sw;
      res.kind  <= kind_1;
      res.data  <= use_ram_1 ? rd_1 : sw_1;
   end

endmodule

`default_nettype wire

// File: design/cmd_decode.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_decode (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       rx_valid,
   input  wire logic [7:0] rx_byte,
   output logic            cmd_valid,
   output monitor_pkg::cmd_t cmd
);

   import monitor_pkg::*;

   logic [1:0]              byte_cnt;
   logic [gap_cnt_bits-1:0] gap_cnt;
   logic [7:0]              op_q;
   logic [7:0]              addr_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         byte_cnt  <= 2'd0;
         gap_cnt   <= '0;
         cmd_valid <= 1'b0;
      end else begin
         cmd_valid <= 1'b0;
         if (rx_valid) begin
            gap_cnt <= '0;
            case (byte_cnt)
               2'd0: byte_cnt <= 2'd1;
               2'd1: byte_cnt <= 2'd2;
               default: begin
                  byte_cnt  <= 2'd0;
                  cmd_valid <= 1'b1;
               end
            endcase
         end else if (byte_cnt != 2'd0) begin
            // stale partial frame, start over with an opcode.
            if (gap_cnt == gap_last) begin
               byte_cnt <= 2'd0;
               gap_cnt  <= '0;
            end else begin
               gap_cnt <= gap_cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid) begin
         case (byte_cnt)
            2'd0: op_q <= rx_byte;
            2'd1: addr_q <= rx_byte;
            default: begin
               cmd.op   <= op_q;
               cmd.addr <= addr_q;
               cmd.data <= rx_byte;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       tx_start,
   input  wire logic [7:0] tx_byte,
   output logic            txd
);

   import monitor_pkg::*;

   logic                    busy;
   logic [bit_cnt_bits-1:0] cnt;
   logic [3:0]              bits_left;
   logic [8:0]              shift;

   always_ff @(posedge clk) begin
      if (rst) begin
         txd       <= 1'b1;
         busy      <= 1'b0;
         cnt       <= '0;
         bits_left <= '0;
      end else if (!busy) begin
         if (tx_start) begin
            // start bit goes out right away.
            txd       <= 1'b0;
            busy      <= 1'b1;
            cnt       <= '0;
            bits_left <= 4'd9;
         end
      end else if (cnt == bit_last) begin
         cnt <= '0;
         if (bits_left == 4'd0) begin
            busy <= 1'b0;
         end else begin
            txd       <= shift[0];
            bits_left <= bits_left - 1'b1;
         end
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // data bits then the stop bit, lsb first.
   always_ff @(posedge clk) begin
      if (!busy && tx_start) begin
         shift <= {1'b1, tx_byte};
      end else if (busy && cnt == bit_last) begin
         shift <= {1'b1, shift[8:1]};
      end
   end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       rxd,
   output logic            rx_valid,
   output logic [7:0]      rx_byte
);

   import monitor_pkg::*;

   typedef enum logic [1:0] {
      s_idle,
      s_start,
      s_data,
      s_stop
   } state_e;

   state_e                  state;
   logic                    rxd_meta;
   logic                    rxd_s;
   logic                    rxd_prev;
   logic [bit_cnt_bits-1:0] cnt;
   logic [2:0]              bit_idx;
   logic [7:0]              shift;

   assign rx_byte = shift;

   always_ff @(posedge clk) begin
      if (rst) begin
         rxd_meta <= 1'b1;
         rxd_s    <= 1'b1;
         rxd_prev <= 1'b1;
         state    <= s_idle;
         cnt      <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rxd_meta <= rxd;
         rxd_s    <= rxd_meta;
         rxd_prev <= rxd_s;
         rx_valid <= 1'b0;
         case (state)
            s_idle: begin
               // wait for a high to low edge on the synchronized line.
               if (rxd_prev && !rxd_s) begin
                  state <= s_start;
                  cnt   <= '0;
               end
            end
            s_start: begin
               if (cnt == half_last) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  // a glitch shorter than half a bit is ignored.
                  state   <= rxd_s ? s_idle : s_data;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            s_data: begin
               if (cnt == bit_last) begin
                  cnt <= '0;
                  if (bit_idx == 3'd7) begin
                     state <= s_stop;
                  end
                  bit_idx <= bit_idx + 1'b1;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: begin
               if (cnt == bit_last) begin
                  rx_valid <= rxd_s;
                  state    <= s_idle;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // lsb arrives first.
   always_ff @(posedge clk) begin
      if (state == s_data && cnt == bit_last) begin
         shift <= {rxd_s, shift[7:1]};
      end
   end

endmodule

`default_nettype wire

// File: design/monitor_pkg.sv
`default_nettype none

package monitor_pkg;

   localparam int clkspeed = 40000000;
   localparam int baud = 115200;
   localparam int clks_per_bit = clkspeed / baud;

   // bit-time counter, shared by both uart blocks.
   localparam int bit_cnt_bits = $clog2(clks_per_bit);
   localparam logic [bit_cnt_bits-1:0] bit_last = bit_cnt_bits'(clks_per_bit - 1);
   localparam logic [bit_cnt_bits-1:0] half_last = bit_cnt_bits'(clks_per_bit / 2 - 1);

   localparam int ram_addr_bits = 8;

   // inter-byte timeout, in bit times and in cycles.
   localparam int gap_bits = 20;
   localparam int gap_cnt_bits = $clog2(gap_bits * clks_per_bit + 1);
   localparam logic [gap_cnt_bits-1:0] gap_last = gap_cnt_bits'(gap_bits * clks_per_bit);

   localparam logic [7:0] ack_byte = 8'h4B;
   localparam logic [7:0] bad_byte = 8'h3F;

   typedef enum logic [7:0] {
      op_write  = 8'h57,
      op_read   = 8'h52,
      op_led    = 8'h4C,
      op_switch = 8'h53
   } op_e;

   typedef struct packed {
      logic [7:0] op;
      logic [7:0] addr;
      logic [7:0] data;
   } cmd_t;

   typedef enum logic [1:0] {
      res_ack,
      res_data,
      res_bad
   } res_kind_e;

   typedef struct packed {
      res_kind_e  kind;
      logic [7:0] data;
   } result_t;

endpackage

`default_nettype wire
